/* src/uart_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared constants for the UART receive bank.
//////////////////////////////////////////////////////////////////////

package uart_pkg;

  // Number of independent serial lines.
  localparam int NUM_CHANNELS = 4;

  // Width of a channel number on the output port.
  localparam int CHANNEL_BITS = $clog2(NUM_CHANNELS);

  // Frame format.
  localparam int DATA_BITS = 8;
  localparam int STOP_BITS = 2;

  // Ticks per bit period.
  localparam int OVERSAMPLE = 16;

  // Clock cycles per oversampling tick, so one bit is
  // OVERSAMPLE * TICK_DIVIDER clocks long.
  localparam int TICK_DIVIDER = 4;

endpackage : uart_pkg

/* src/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen (
  input  logic i_clock,
  input  logic i_reset,
  output logic o_tick
);

  import uart_pkg::*;

  logic [$clog2(TICK_DIVIDER)-1:0] count;

  // Down-counter, one tick per wrap.
  // The counter starts full after reset, so the first tick is a whole period away.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      count  <= ($clog2(TICK_DIVIDER))'(TICK_DIVIDER - 1);
      o_tick <= 1'b0;
    end else if (count == '0) begin
      count  <= ($clog2(TICK_DIVIDER))'(TICK_DIVIDER - 1);
      o_tick <= 1'b1;
    end else begin
      count  <= count - 1'b1;
      o_tick <= 1'b0;
    end
  end

endmodule : baud_tick_gen

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic                           i_clock,
  input  logic                           i_reset,
  input  logic                           i_tick,
  input  logic                           i_rx,
  output logic                           o_done,
  output logic                           o_frame_error,
  output logic [uart_pkg::DATA_BITS-1:0] o_data
);

  import uart_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE  = 4'b0001,
    ST_START = 4'b0010,
    ST_DATA  = 4'b0100,
    ST_STOP  = 4'b1000
  } state_t;

  state_t state;

  logic                             rx_meta;
  logic                             rx_sync;
  logic [$clog2(OVERSAMPLE)-1:0]    tick_cnt;
  logic [$clog2(DATA_BITS)-1:0]     bit_cnt;
  logic [$clog2(STOP_BITS+1)-1:0]   stop_cnt;
  logic [DATA_BITS-1:0]             shift_reg;
  logic                             stop_err;

  logic bit_mid;
  logic data_sample;
  logic last_data;
  logic stop_sample;
  logic last_stop;

  //////////////////////////////////////////////////////////////////////
  // Sample strobes
  //////////////////////////////////////////////////////////////////////

  // A full bit period after the previous middle.
  assign bit_mid     = i_tick && (tick_cnt == OVERSAMPLE - 1);
  assign data_sample = (state == ST_DATA) && bit_mid;
  assign last_data   = data_sample && (bit_cnt == DATA_BITS - 1);
  assign stop_sample = (state == ST_STOP) && bit_mid;
  assign last_stop   = stop_sample && (stop_cnt == STOP_BITS - 1);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      stop_cnt <= '0;
      o_done   <= 1'b0;
      // Line idles high.
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      o_done  <= last_stop;

      case (state)
        ST_IDLE: begin
          if (i_tick && !rx_sync) begin
            state    <= ST_START;
            tick_cnt <= '0;
          end
        end

        ST_START: begin
          if (i_tick) begin
            if (tick_cnt == OVERSAMPLE / 2 - 1) begin
              // Middle of the start bit, drop it if the line went back high.
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rx_sync ? ST_IDLE : ST_DATA;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        ST_DATA: begin
          if (i_tick) begin
            if (bit_mid) begin
              tick_cnt <= '0;
              if (last_data) begin
                stop_cnt <= '0;
                state    <= ST_STOP;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        ST_STOP: begin
          if (i_tick) begin
            if (bit_mid) begin
              tick_cnt <= '0;
              if (last_stop) begin
                state <= ST_IDLE;
              end else begin
                stop_cnt <= stop_cnt + 1'b1;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    // LSB arrives first, so shift in from the top.
    if (data_sample) begin
      shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
    end

    // Any low stop sample marks the frame bad.
    if (last_data) begin
      stop_err <= 1'b0;
    end else if (stop_sample && !rx_sync) begin
      stop_err <= 1'b1;
    end

    if (last_stop) begin
      o_data        <= shift_reg;
      o_frame_error <= stop_err | ~rx_sync;
    end
  end

endmodule : uart_rx

/* src/rx_collector.sv */
`timescale 1ns/1ps

module rx_collector (
  input  logic                                                    i_clock,
  input  logic                                                    i_reset,
  input  logic [uart_pkg::NUM_CHANNELS-1:0]                       i_done,
  input  logic [uart_pkg::NUM_CHANNELS-1:0]                       i_frame_error,
  input  logic [uart_pkg::NUM_CHANNELS-1:0][uart_pkg::DATA_BITS-1:0] i_data,
  output logic                                                    o_valid,
  output logic                                                    o_frame_error,
  output logic [uart_pkg::CHANNEL_BITS-1:0]                       o_channel,
  output logic [uart_pkg::DATA_BITS-1:0]                          o_data
);

  import uart_pkg::*;

  logic [NUM_CHANNELS-1:0]                pending;
  logic [NUM_CHANNELS-1:0][DATA_BITS-1:0] data_q;
  logic [NUM_CHANNELS-1:0]                err_q;
  logic [CHANNEL_BITS-1:0]                ptr;

  logic                                   grant_valid;
  logic [CHANNEL_BITS-1:0]                grant_idx;

  //////////////////////////////////////////////////////////////////////
  // Round-robin search starting at the pointer
  //////////////////////////////////////////////////////////////////////

  always_comb begin : grant_search
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int j = 0; j < NUM_CHANNELS; j++) begin
      idx = (int'(ptr) + j) % NUM_CHANNELS;
      if (!grant_valid && pending[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = CHANNEL_BITS'(idx);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pending slots and pointer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      pending <= '0;
      ptr     <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= grant_valid;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        // A new byte wins over the clear.
        if (i_done[c]) begin
          pending[c] <= 1'b1;
        end else if (grant_valid && grant_idx == c) begin
          pending[c] <= 1'b0;
        end
      end
      // Move past the granted channel.
      if (grant_valid) begin
        ptr <= (grant_idx == NUM_CHANNELS - 1) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  // Byte copies and output register.
  always_ff @(posedge i_clock) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (i_done[c]) begin
        data_q[c] <= i_data[c];
        err_q[c]  <= i_frame_error[c];
      end
    end
    if (grant_valid) begin
      o_channel     <= grant_idx;
      o_data        <= data_q[grant_idx];
      o_frame_error <= err_q[grant_idx];
    end
  end

endmodule : rx_collector

/* src/uart_rx_bank.sv */
`timescale 1ns/1ps

module uart_rx_bank (
  input  logic                              i_clock,
  input  logic                              i_reset,
  input  logic [uart_pkg::NUM_CHANNELS-1:0] i_rx,
  output logic                              o_valid,
  output logic                              o_frame_error,
  output logic [uart_pkg::CHANNEL_BITS-1:0] o_channel,
  output logic [uart_pkg::DATA_BITS-1:0]    o_data
);

  import uart_pkg::*;

  logic                                   tick;
  logic [NUM_CHANNELS-1:0]                done;
  logic [NUM_CHANNELS-1:0]                frame_err;
  logic [NUM_CHANNELS-1:0][DATA_BITS-1:0] rx_byte;

  // Shared oversampling strobe.
  baud_tick_gen tick_gen_i (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .o_tick  (tick)
  );

  // One receiver per serial line.
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : gen_rx
    uart_rx uart_rx_i (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_tick        (tick),
      .i_rx          (i_rx[c]),
      .o_done        (done[c]),
      .o_frame_error (frame_err[c]),
      .o_data        (rx_byte[c])
    );
  end

  // Round-robin merge onto the byte port.
  rx_collector collector_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_done        (done),
    .i_frame_error (frame_err),
    .i_data        (rx_byte),
    .o_valid       (o_valid),
    .o_frame_error (o_frame_error),
    .o_channel     (o_channel),
    .o_data        (o_data)
  );

endmodule : uart_rx_bank

/* sim/uart_rx_bank_properties.sv */
`timescale 1ns/1ps

module uart_rx_bank_properties (
  input logic                              i_clock,
  input logic                              i_reset,
  input logic                              i_tick,
  input logic                              i_valid,
  input logic [uart_pkg::CHANNEL_BITS-1:0] i_channel
);

  //////////////////////////////////////////////////////////////////////
  // Output strobe
  //////////////////////////////////////////////////////////////////////

  // One strobe per byte and never two in a row for one channel.
  valid_single: assert property (
    @(posedge i_clock) disable iff (!i_reset)
    i_valid |=> !(i_valid && i_channel == $past(i_channel))
  ) else $error("o_valid held for two cycles on channel %0d", i_channel);

  // Everything is quiet right after reset.
  quiet_after_reset: assert property (
    @(posedge i_clock)
    $rose(i_reset) |=> (!i_valid && !i_tick)
  ) else $error("o_valid or tick high in the first cycle after reset");

  //////////////////////////////////////////////////////////////////////
  // Tick strobe
  //////////////////////////////////////////////////////////////////////

  tick_single: assert property (
    @(posedge i_clock) disable iff (!i_reset)
    i_tick |=> !i_tick
  ) else $error("tick high for two consecutive cycles");

endmodule : uart_rx_bank_properties

// Tick is internal to the top level.
bind uart_rx_bank uart_rx_bank_properties uart_rx_bank_properties_i (
  .i_clock   (i_clock),
  .i_reset   (i_reset),
  .i_tick    (tick),
  .i_valid   (o_valid),
  .i_channel (o_channel)
);

/* sim/uart_rx_bank_tb.sv */
`timescale 1ns/1ps

module uart_rx_bank_tb;

  import uart_pkg::*;

  localparam int          BIT_CLOCKS    = OVERSAMPLE * TICK_DIVIDER;
  localparam int unsigned SEED          = 32'h4ce0_26f2;
  localparam int          RANDOM_FRAMES = 200;
  localparam int          DRAIN_LIMIT   = 4 * BIT_CLOCKS;
  localparam int          QUIET_CYCLES  = 12 * BIT_CLOCKS;

  logic                    i_clock;
  logic                    i_reset;
  logic [NUM_CHANNELS-1:0] i_rx;
  logic                    o_valid;
  logic                    o_frame_error;
  logic [CHANNEL_BITS-1:0] o_channel;
  logic [DATA_BITS-1:0]    o_data;

  // Expected {frame error, byte} per channel in arrival order.
  logic [DATA_BITS:0]      exp_q[NUM_CHANNELS][$];
  logic [CHANNEL_BITS-1:0] order_q[$];
  logic [DATA_BITS-1:0]    stim_data[NUM_CHANNELS][$];
  int                      stim_gap[NUM_CHANNELS][$];

  string test_name;
  int    valid_count;
  // Model of the collector's rotating pointer.
  int    next_ptr;

  uart_rx_bank uart_rx_bank_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_rx          (i_rx),
    .o_valid       (o_valid),
    .o_frame_error (o_frame_error),
    .o_channel     (o_channel),
    .o_data        (o_data)
  );

  always #2 i_clock = ~i_clock;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic int pending_count();
    int total;
    total = 0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      total += exp_q[c].size();
    end
    return total;
  endfunction

  // Holds one line level for a whole bit period.
  task automatic drive_bit(input int ch, input logic level);
    i_rx[ch] = level;
    repeat (BIT_CLOCKS) @(negedge i_clock);
  endtask

  // Start bit, data LSB first, then the stop bits.
  // A bad_stop index in range forces that stop bit low.
  task automatic send_frame(input int ch, input logic [DATA_BITS-1:0] data, input int bad_stop);
    exp_q[ch].push_back({(bad_stop >= 0 && bad_stop < STOP_BITS), data});
    drive_bit(ch, 1'b0);
    for (int b = 0; b < DATA_BITS; b++) begin
      drive_bit(ch, data[b]);
    end
    for (int s = 0; s < STOP_BITS; s++) begin
      drive_bit(ch, (s == bad_stop) ? 1'b0 : 1'b1);
    end
    // Line returns to idle after a forced low stop bit.
    i_rx[ch] = 1'b1;
  endtask

  task automatic wait_drained(input int limit);
    int cycles;
    cycles = 0;
    while (pending_count() != 0) begin
      @(negedge i_clock);
      cycles++;
      if (cycles > limit) begin
        $display("Timed out in %s with %0d bytes still undelivered",
                 test_name, pending_count());
        stop_on_error();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  task automatic check_output();
    logic [DATA_BITS:0] expected;
    logic [DATA_BITS:0] actual;
    valid_count++;
    order_q.push_back(o_channel);
    next_ptr = (int'(o_channel) + 1) % NUM_CHANNELS;
    actual   = {o_frame_error, o_data};
    assert (exp_q[o_channel].size() > 0) else begin
      $display("In %s a byte came out on channel %0d, but none was sent there",
               test_name, o_channel);
      stop_on_error();
    end
    expected = exp_q[o_channel].pop_front();
    assert (actual == expected) else begin
      $display("** Error %s: channel %0d expected data 0x%02h err %0b, actual data 0x%02h err %0b",
               test_name, o_channel, expected[DATA_BITS-1:0], expected[DATA_BITS],
               actual[DATA_BITS-1:0], actual[DATA_BITS]);
      stop_on_error();
    end
  endtask

  // Outputs settle after the rising edge.
  always @(negedge i_clock) begin
    if (i_reset && o_valid) begin
      check_output();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic one_per_channel();
    logic [DATA_BITS-1:0] pattern[NUM_CHANNELS];
    pattern = '{8'h01, 8'h80, 8'h3c, 8'hd2};
    test_name = "one_per_channel";
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      send_frame(c, pattern[c], -1);
      wait_drained(DRAIN_LIMIT);
    end
  endtask

  task automatic check_order(input int first);
    int want;
    assert (order_q.size() == NUM_CHANNELS) else begin
      $display("** Error %s: expected %0d bytes, actual %0d",
               test_name, NUM_CHANNELS, order_q.size());
      stop_on_error();
    end
    for (int k = 0; k < NUM_CHANNELS; k++) begin
      want = (first + k) % NUM_CHANNELS;
      assert (int'(order_q[k]) == want) else begin
        $display("** Error %s: grant %0d expected channel %0d, actual channel %0d",
                 test_name, k, want, order_q[k]);
        stop_on_error();
      end
    end
  endtask

  task automatic simultaneous_start();
    int                   first;
    logic [DATA_BITS-1:0] data[NUM_CHANNELS];
    test_name = "simultaneous_start";
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      data[c] = DATA_BITS'($urandom);
    end
    // Move the pointer off channel 0 first.
    send_frame(1, DATA_BITS'($urandom), -1);
    wait_drained(DRAIN_LIMIT);
    first = next_ptr;
    order_q.delete();
    fork
      send_frame(0, data[0], -1);
      send_frame(1, data[1], -1);
      send_frame(2, data[2], -1);
      send_frame(3, data[3], -1);
    join
    wait_drained(DRAIN_LIMIT);
    check_order(first);
  endtask

  task automatic framing_error();
    test_name = "framing_error";
    send_frame(3, 8'h5a, 1);
    // Line idles so the low stop bit cannot run into the next start.
    repeat (2 * BIT_CLOCKS) @(negedge i_clock);
    send_frame(3, 8'h96, -1);
    wait_drained(DRAIN_LIMIT);
  endtask

  task automatic back_to_back();
    test_name = "back_to_back";
    send_frame(1, 8'hff, -1);
    send_frame(1, 8'h00, -1);
    send_frame(1, 8'ha5, -1);
    send_frame(1, 8'h7e, -1);
    wait_drained(DRAIN_LIMIT);
  endtask

  task automatic short_glitch();
    int count_before;
    test_name    = "short_glitch";
    count_before = valid_count;
    i_rx[2] = 1'b0;
    repeat (BIT_CLOCKS / 4) @(negedge i_clock);
    i_rx[2] = 1'b1;
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge i_clock);
    end
    assert (valid_count == count_before && pending_count() == 0) else begin
      $display("A low pulse of a quarter bit on channel 2 produced output");
      stop_on_error();
    end
  endtask

  // Each channel sends its share after random idle gaps.
  task automatic run_channel(input int ch);
    int                   gap;
    logic [DATA_BITS-1:0] data;
    while (stim_data[ch].size() > 0) begin
      gap  = stim_gap[ch].pop_front();
      data = stim_data[ch].pop_front();
      repeat (gap) @(negedge i_clock);
      send_frame(ch, data, -1);
    end
  endtask

  task automatic random_traffic();
    int ch;
    test_name = "random_traffic";
    for (int i = 0; i < RANDOM_FRAMES; i++) begin
      ch = int'($urandom % NUM_CHANNELS);
      stim_data[ch].push_back(DATA_BITS'($urandom));
      stim_gap[ch].push_back(int'($urandom % (2 * BIT_CLOCKS)));
    end
    fork
      run_channel(0);
      run_channel(1);
      run_channel(2);
      run_channel(3);
    join
    wait_drained(DRAIN_LIMIT);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    i_clock     = 1'b0;
    i_reset     = 1'b0;
    i_rx        = '1;
    test_name   = "reset";
    valid_count = 0;
    next_ptr    = 0;
    repeat (2) @(posedge i_clock);
    @(negedge i_clock);
    i_reset = 1'b1;
    repeat (BIT_CLOCKS) @(negedge i_clock);

    one_per_channel();
    simultaneous_start();
    framing_error();
    back_to_back();
    short_glitch();
    random_traffic();

    if (pending_count() != 0) begin
      $display("The run ended with %0d expected bytes never delivered", pending_count());
      stop_on_error();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule : uart_rx_bank_tb

/* compile.f */
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/rx_collector.sv
src/uart_rx_bank.sv
sim/uart_rx_bank_properties.sv
sim/uart_rx_bank_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART receive bank simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module uart_rx_bank_tb -f compile.f -o uart_rx_bank_sim \
  && ./obj_dir/uart_rx_bank_sim | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
